// ==== hdl/axi_write_pkg.sv ====
/*
  AXI write master shared definitions
  Bus widths, burst geometry and the packed structs passed between
  the request setup, the channel blocks and the response tracker
*/
package axi_write_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and burst geometry
  ////////////////////////////////////////////////////////////
  localparam int ADDR_WIDTH         = 32;
  localparam int DATA_WIDTH         = 32;
  localparam int BYTES_PER_BEAT     = 4;
  localparam int LOG_BYTES_PER_BEAT = 2;
  localparam int BURST_BEATS        = 256;
  localparam int LOG_BURST_BEATS    = 8;
  // A full burst never crosses this boundary
  localparam int BURST_BYTES        = 1024;

  ////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////
  typedef logic [ADDR_WIDTH-1:0]     addr_t;
  typedef logic [31:0]               len_t;
  // Burst count minus one, total beats with the in-burst bits dropped
  typedef logic [ADDR_WIDTH-LOG_BYTES_PER_BEAT-LOG_BURST_BEATS-1:0] txn_count_t;
  // AXI awlen encoding
  typedef logic [LOG_BURST_BEATS-1:0] beat_count_t;
  typedef logic [BYTES_PER_BEAT-1:0]  strb_t;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////
  // Burst plan derived once per request
  typedef struct packed {
    addr_t       base_addr;
    txn_count_t  last_txn;
    beat_count_t final_len;
    strb_t       final_strb;
    logic        single_burst;
  } burst_plan_t;

  // Write address payload
  typedef struct packed {
    addr_t       awaddr;
    beat_count_t awlen;
  } aw_beat_t;

  // Write data payload
  typedef struct packed {
    logic [DATA_WIDTH-1:0] wdata;
    strb_t                 wstrb;
    logic                  wlast;
  } w_beat_t;

endpackage

// ==== hdl/write_request_setup.sv ====
/*
  Write request setup
  Samples the start address and byte count on ctrl_start, then works
  out the burst plan and issues a start level two cycles later
*/
`timescale 1ns/1ns

module write_request_setup (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       ctrl_start,
  input  axi_write_pkg::addr_t       ctrl_addr_offset,
  input  axi_write_pkg::len_t        ctrl_xfer_size_in_bytes,
  output logic                       start,
  output axi_write_pkg::burst_plan_t plan
);
  import axi_write_pkg::*;

  // Beats in the request minus one
  localparam int TOTAL_W = $bits(len_t) - LOG_BYTES_PER_BEAT;

  logic                          ctrl_start_d1;
  addr_t                         base_addr_r;
  logic [TOTAL_W-1:0]            total_len_r;
  // Byte remainder minus one, wraps to all ones for a whole word
  logic [LOG_BYTES_PER_BEAT-1:0] rem_m1_r;
  beat_count_t                   final_len_r;
  strb_t                         final_strb_r;
  logic                          single_burst_r;

  ////////////////////////////////////////////////////////////
  // Start delay line
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_start_d1 <= 1'b0;
      start         <= 1'b0;
    end else begin
      ctrl_start_d1 <= ctrl_start;
      start         <= ctrl_start_d1;
    end
  end

  // First stage, raw request
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      base_addr_r <= ctrl_addr_offset & ~addr_t'(BURST_BYTES - 1);
      // Round up to whole words
      if (ctrl_xfer_size_in_bytes[LOG_BYTES_PER_BEAT-1:0] != '0) begin
        total_len_r <= ctrl_xfer_size_in_bytes[LOG_BYTES_PER_BEAT +: TOTAL_W];
      end else begin
        total_len_r <= ctrl_xfer_size_in_bytes[LOG_BYTES_PER_BEAT +: TOTAL_W] - 1'b1;
      end
      rem_m1_r <= ctrl_xfer_size_in_bytes[LOG_BYTES_PER_BEAT-1:0] - 1'b1;
    end
  end

  // Second stage, final burst shape
  always_ff @(posedge aclk) begin
    if (ctrl_start_d1) begin
      final_len_r    <= total_len_r[LOG_BURST_BEATS-1:0];
      single_burst_r <= (total_len_r[TOTAL_W-1:LOG_BURST_BEATS] == '0);
      // Byte k live when k <= remainder - 1
      for (int k = 0; k < BYTES_PER_BEAT; k++) begin
        final_strb_r[k] <= (k <= int'(rem_m1_r));
      end
    end
  end

  always_comb begin
    plan.base_addr    = base_addr_r;
    plan.last_txn     = total_len_r[TOTAL_W-1:LOG_BURST_BEATS];
    plan.final_len    = final_len_r;
    plan.final_strb   = final_strb_r;
    plan.single_burst = single_burst_r;
  end

endmodule

// ==== hdl/write_data_channel.sv ====
/*
  Write data channel
  Passes stream beats onto the W channel while a request runs, marks
  the last beat of each burst, applies the final strobe and flags the
  first beat of every burst to the address side
*/
`timescale 1ns/1ns

module write_data_channel (
  input  logic                                 aclk,
  input  logic                                 areset,
  input  logic                                 start,
  input  axi_write_pkg::burst_plan_t           plan,
  input  logic                                 s_axis_tvalid,
  output logic                                 s_axis_tready,
  input  logic [axi_write_pkg::DATA_WIDTH-1:0] s_axis_tdata,
  output logic                                 m_axi_wvalid,
  input  logic                                 m_axi_wready,
  output axi_write_pkg::w_beat_t               m_axi_w,
  output logic                                 first_beat_seen
);
  import axi_write_pkg::*;

  logic        running;
  logic        wxfer;
  logic        wlast;
  logic        final_txn;
  logic        final_xfer;
  beat_count_t beats_left;
  txn_count_t  w_txn_left;
  // Next beat presented opens a burst
  logic        wfirst;
  logic        first_taken;
  logic        first_req;
  logic        first_req_d1;

  ////////////////////////////////////////////////////////////
  // Stream to W gating
  ////////////////////////////////////////////////////////////
  assign m_axi_wvalid  = s_axis_tvalid & running;
  assign s_axis_tready = m_axi_wready & running;
  assign wxfer         = m_axi_wvalid & m_axi_wready;

  assign wlast      = (beats_left == '0);
  assign final_txn  = (w_txn_left == '0);
  assign final_xfer = wxfer & wlast & final_txn;

  always_comb begin
    m_axi_w.wdata = s_axis_tdata;
    m_axi_w.wlast = wlast;
    // Only the very last beat carries a partial strobe
    m_axi_w.wstrb = (wlast & final_txn) ? plan.final_strb : '1;
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (final_xfer) begin
      running <= 1'b0;
    end
  end

  // Beats left in the current burst
  always_ff @(posedge aclk) begin
    if (areset) begin
      beats_left <= '1;
    end else if (start) begin
      beats_left <= plan.single_burst ? plan.final_len : beat_count_t'(BURST_BEATS - 1);
    end else if (wxfer & wlast) begin
      // Reload for the next burst, short if it is the final one
      beats_left <= (w_txn_left == txn_count_t'(1)) ? plan.final_len
                                                    : beat_count_t'(BURST_BEATS - 1);
    end else if (wxfer) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  // Bursts left after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      w_txn_left <= '0;
    end else if (start) begin
      w_txn_left <= plan.last_txn;
    end else if (wxfer & wlast & ~final_txn) begin
      w_txn_left <= w_txn_left - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // First beat detection
  ////////////////////////////////////////////////////////////
  assign first_req = m_axi_wvalid & wfirst & ~first_taken;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst          <= 1'b1;
      first_taken     <= 1'b0;
      first_req_d1    <= 1'b0;
      first_beat_seen <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      // Burst end rearms even when the first beat was also the last
      if (wxfer & wlast) begin
        first_taken <= 1'b0;
      end else if (first_req) begin
        first_taken <= 1'b1;
      end
      first_req_d1    <= first_req;
      first_beat_seen <= first_req_d1;
    end
  end

endmodule

// ==== hdl/write_addr_channel.sv ====
/*
  Write address channel
  Sends one AW transfer per burst, only after the data side reports
  that burst's first beat, and holds off while the response tracker
  reports the outstanding limit
*/
`timescale 1ns/1ns

module write_addr_channel (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  axi_write_pkg::burst_plan_t plan,
  input  logic                       first_beat_seen,
  input  logic                       aw_stall,
  output logic                       m_axi_awvalid,
  input  logic                       m_axi_awready,
  output axi_write_pkg::aw_beat_t    m_axi_aw,
  output logic                       aw_handshake
);
  import axi_write_pkg::*;

  // Bursts with data under way but no address yet
  txn_count_t aw_pending;
  txn_count_t aw_txn_left;
  addr_t      addr_r;
  logic       final_txn;

  assign aw_handshake = m_axi_awvalid & m_axi_awready;
  assign final_txn    = (aw_txn_left == '0);

  ////////////////////////////////////////////////////////////
  // Pending burst count
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_pending <= '0;
    end else if (first_beat_seen & ~aw_handshake) begin
      aw_pending <= aw_pending + 1'b1;
    end else if (aw_handshake & ~first_beat_seen) begin
      aw_pending <= aw_pending - 1'b1;
    end
  end

  // Valid rises when work waits and a slot is free, then holds
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (~m_axi_awvalid) begin
      m_axi_awvalid <= (aw_pending != '0) & ~aw_stall;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and length
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (start) begin
      addr_r <= plan.base_addr;
    end else if (aw_handshake) begin
      addr_r <= addr_r + addr_t'(BURST_BYTES);
    end
  end

  // Bursts left to address after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      aw_txn_left <= '0;
    end else if (start) begin
      aw_txn_left <= plan.last_txn;
    end else if (aw_handshake & ~final_txn) begin
      aw_txn_left <= aw_txn_left - 1'b1;
    end
  end

  always_comb begin
    m_axi_aw.awaddr = addr_r;
    // Full bursts everywhere but the tail
    m_axi_aw.awlen  = final_txn ? plan.final_len : beat_count_t'(BURST_BEATS - 1);
  end

endmodule

// ==== hdl/write_response_tracker.sv ====
/*
  Write response tracker
  Keeps the count of free outstanding slots, stalls the address side
  when none are left, and pulses done on the final B response
*/
`timescale 1ns/1ns

module write_response_tracker #(
  parameter int unsigned max_outstanding = 4
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  axi_write_pkg::burst_plan_t plan,
  input  logic                       aw_handshake,
  input  logic                       m_axi_bvalid,
  output logic                       m_axi_bready,
  output logic                       aw_stall,
  output logic                       ctrl_done
);
  import axi_write_pkg::*;

  localparam int VAC_W = $clog2(max_outstanding + 1);

  logic [VAC_W-1:0] vacancy;
  txn_count_t       b_txn_left;
  logic             bxfer;
  logic             busy;
  logic             final_resp;

  // Responses are always accepted
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;
  assign aw_stall     = (vacancy == '0);
  assign final_resp   = busy & bxfer & (b_txn_left == '0);

  // Free slots, address takes one and a response gives it back
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= VAC_W'(max_outstanding);
    end else if (aw_handshake & ~bxfer) begin
      vacancy <= vacancy - 1'b1;
    end else if (bxfer & ~aw_handshake) begin
      vacancy <= vacancy + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response countdown and done
  ////////////////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      busy       <= 1'b0;
      b_txn_left <= '0;
      ctrl_done  <= 1'b0;
    end else begin
      ctrl_done <= final_resp;
      if (start) begin
        busy       <= 1'b1;
        b_txn_left <= plan.last_txn;
      end else if (final_resp) begin
        busy <= 1'b0;
      end else if (bxfer & (b_txn_left != '0)) begin
        b_txn_left <= b_txn_left - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/axi_write_master.sv ====
/*
  AXI4 write master
  Moves a stream of words to a memory-mapped slave as a series of
  incrementing bursts, with a bounded number of bursts in flight
*/
`timescale 1ns/1ns

module axi_write_master #(
  parameter int unsigned max_outstanding = 4
) (
  input  logic                                 aclk,
  input  logic                                 areset,
  // Control
  input  logic                                 ctrl_start,
  input  axi_write_pkg::addr_t                 ctrl_addr_offset,
  input  axi_write_pkg::len_t                  ctrl_xfer_size_in_bytes,
  output logic                                 ctrl_done,
  // Stream in
  input  logic                                 s_axis_tvalid,
  output logic                                 s_axis_tready,
  input  logic [axi_write_pkg::DATA_WIDTH-1:0] s_axis_tdata,
  // AXI write address
  output logic                                 m_axi_awvalid,
  input  logic                                 m_axi_awready,
  output axi_write_pkg::aw_beat_t              m_axi_aw,
  // AXI write data
  output logic                                 m_axi_wvalid,
  input  logic                                 m_axi_wready,
  output axi_write_pkg::w_beat_t               m_axi_w,
  // AXI write response
  input  logic                                 m_axi_bvalid,
  output logic                                 m_axi_bready
);
  import axi_write_pkg::*;

  logic        start;
  burst_plan_t plan;
  logic        first_beat_seen;
  logic        aw_handshake;
  logic        aw_stall;

  ////////////////////////////////////////////////////////////
  // Request setup
  ////////////////////////////////////////////////////////////
  write_request_setup u_setup (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .start                   (start),
    .plan                    (plan)
  );

  ////////////////////////////////////////////////////////////
  // Data and address channels side by side
  ////////////////////////////////////////////////////////////
  write_data_channel u_wdata (
    .aclk            (aclk),
    .areset          (areset),
    .start           (start),
    .plan            (plan),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tdata    (s_axis_tdata),
    .m_axi_wvalid    (m_axi_wvalid),
    .m_axi_wready    (m_axi_wready),
    .m_axi_w         (m_axi_w),
    .first_beat_seen (first_beat_seen)
  );

  write_addr_channel u_waddr (
    .aclk            (aclk),
    .areset          (areset),
    .start           (start),
    .plan            (plan),
    .first_beat_seen (first_beat_seen),
    .aw_stall        (aw_stall),
    .m_axi_awvalid   (m_axi_awvalid),
    .m_axi_awready   (m_axi_awready),
    .m_axi_aw        (m_axi_aw),
    .aw_handshake    (aw_handshake)
  );

  // Responses, outstanding limit and done
  write_response_tracker #(
    .max_outstanding (max_outstanding)
  ) u_resp (
    .aclk         (aclk),
    .areset       (areset),
    .start        (start),
    .plan         (plan),
    .aw_handshake (aw_handshake),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .aw_stall     (aw_stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

// ==== dv/axi_write_master_tb.sv ====
/*
  AXI write master testbench
  Drives requests and a word stream into the DUT, models an AXI slave
  with optional back-pressure and held responses, and checks the reset
  state, addresses, data beats, outstanding limit and done pulse
*/
`timescale 1ns/1ns

module axi_write_master_tb;
  import axi_write_pkg::*;

  // Beats over all tests set the data pool size and the run limit
  localparam int TOTAL_BEATS = 3 + 650 + 376 + 1536 + 750 + 25;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 2000;
  localparam int LIMIT       = 4;
  localparam logic [31:0] SEED = 32'h2bb5_172d;

  logic                  aclk;
  logic                  areset;
  logic                  ctrl_start;
  addr_t                 ctrl_addr_offset;
  len_t                  ctrl_xfer_size_in_bytes;
  logic                  ctrl_done;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic [DATA_WIDTH-1:0] s_axis_tdata;
  logic                  m_axi_awvalid;
  logic                  m_axi_awready;
  aw_beat_t              m_axi_aw;
  logic                  m_axi_wvalid;
  logic                  m_axi_wready;
  w_beat_t               m_axi_w;
  logic                  m_axi_bvalid;
  logic                  m_axi_bready;

  // Random source and stream data
  logic [31:0]           lfsr_state;
  logic [DATA_WIDTH-1:0] data_pool [TOTAL_BEATS];
  int                    pool_idx;
  logic [DATA_WIDTH-1:0] src_q [$];

  // Expected and observed transfers of the current test
  aw_beat_t exp_aw [$];
  aw_beat_t act_aw [$];
  w_beat_t  exp_w [$];
  w_beat_t  act_w [$];

  // Slave model and monitor state
  int       cycle;
  int       src_taken;
  int       aw_total;
  int       wlast_total;
  int       b_total;
  int       presented;
  int       done_total;
  int       last_b_cycle;
  int       done_cycle;
  int       b_at_done;
  int       b_cycle_at_done;
  int       max_in_flight;
  logic     w_next_first;
  logic     first_counted;
  logic     rand_bp;
  logic     hold_b;
  logic     rand_b;
  // Address offered on the last edge without awready
  logic     aw_waiting;
  aw_beat_t aw_held;

  // Bookkeeping
  string cur_test;
  int    errors;
  int    tests_run;
  int    tests_failed;
  int    test_err_base;
  int    test_done_base;
  int    test_requests;
  int    req_bursts;
  int    req_b_base;
  int    req_done_base;

  axi_write_master #(
    .max_outstanding (LIMIT)
  ) dut (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .ctrl_done               (ctrl_done),
    .s_axis_tvalid           (s_axis_tvalid),
    .s_axis_tready           (s_axis_tready),
    .s_axis_tdata            (s_axis_tdata),
    .m_axi_awvalid           (m_axi_awvalid),
    .m_axi_awready           (m_axi_awready),
    .m_axi_aw                (m_axi_aw),
    .m_axi_wvalid            (m_axi_wvalid),
    .m_axi_wready            (m_axi_wready),
    .m_axi_w                 (m_axi_w),
    .m_axi_bvalid            (m_axi_bvalid),
    .m_axi_bready            (m_axi_bready)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////
  // Galois form with taps x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 32'hD000_0001;
    end
    return s;
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] take_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], take_bit()};
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // Slave model driving on the falling edge
  ////////////////////////////////////////////////////////////
  // Bursts with both address and last beat received
  function automatic int completed_bursts();
    return (aw_total < wlast_total) ? aw_total : wlast_total;
  endfunction

  always @(negedge aclk) begin
    if (!areset) begin
      // Stream word holds until taken
      if (src_taken < src_q.size()) begin
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = src_q[src_taken];
      end else begin
        s_axis_tvalid = 1'b0;
      end
      m_axi_wready  = rand_bp ? take_bit() : 1'b1;
      m_axi_awready = rand_bp ? take_bit() : 1'b1;
      // A raised response waits for its transfer
      if (!(m_axi_bvalid && !m_axi_bready)) begin
        m_axi_bvalid = !hold_b && (b_total < completed_bursts()) && (!rand_b || take_bit());
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor on the rising edge
  ////////////////////////////////////////////////////////////
  always @(posedge aclk) begin
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles in test %s, the DUT stopped making progress",
               cycle, cur_test);
      $display("Regression failed");
      $finish;
    end else if (!areset) begin
      // Done first so the response count excludes this edge
      if (ctrl_done) begin
        done_total++;
        done_cycle      = cycle;
        b_at_done       = b_total;
        b_cycle_at_done = last_b_cycle;
      end
      if (m_axi_wvalid && w_next_first && !first_counted) begin
        presented++;
        first_counted = 1'b1;
      end
      // A stalled address keeps its valid and its payload
      if (aw_waiting) begin
        compare_flag("awvalid held under back-pressure", 1'b1, m_axi_awvalid);
        compare_aw("address held under back-pressure", aw_held, m_axi_aw);
      end
      aw_waiting = m_axi_awvalid && !m_axi_awready;
      aw_held    = m_axi_aw;
      if (m_axi_awvalid && m_axi_awready) begin
        if (aw_total >= presented) begin
          report_failure($sformatf("address %0d went out before its burst's first beat",
                                   aw_total));
        end
        act_aw.push_back(m_axi_aw);
        aw_total++;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        act_w.push_back(m_axi_w);
        w_next_first  = m_axi_w.wlast;
        first_counted = 1'b0;
        if (m_axi_w.wlast) begin
          wlast_total++;
        end
      end
      if (s_axis_tvalid && s_axis_tready) begin
        src_taken++;
      end
      if (m_axi_bvalid && m_axi_bready) begin
        b_total++;
        last_b_cycle = cycle;
      end
      if (aw_total - b_total > max_in_flight) begin
        max_in_flight = aw_total - b_total;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic compare_aw(input string what, input aw_beat_t exp, input aw_beat_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected addr %h len %0d, actual addr %h len %0d",
               cur_test, what, exp.awaddr, exp.awlen, act.awaddr, act.awlen);
      errors++;
    end
  endtask

  task automatic compare_w(input string what, input w_beat_t exp, input w_beat_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected data %h strb %b last %b, actual data %h strb %b last %b",
               cur_test, what, exp.wdata, exp.wstrb, exp.wlast,
               act.wdata, act.wstrb, act.wlast);
      errors++;
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (exp != act) begin
      $display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Request helpers
  ////////////////////////////////////////////////////////////
  // Bytes 0 to rem-1 live and a whole word keeps all four
  function automatic strb_t final_strobe(input int rem);
    if (rem == 0) begin
      return '1;
    end
    return strb_t'((1 << rem) - 1);
  endfunction

  task automatic open_test(input string name);
    cur_test = name;
    exp_aw.delete();
    act_aw.delete();
    exp_w.delete();
    act_w.delete();
    test_err_base  = errors;
    test_done_base = done_total;
    test_requests  = 0;
    max_in_flight  = 0;
  endtask

  // Builds the expected bursts and beats and then pulses ctrl_start
  task automatic begin_request(input addr_t addr, input len_t bytes);
    int       beats;
    int       bursts;
    int       rem;
    addr_t    base;
    aw_beat_t ab;
    w_beat_t  wb;
    beats  = (int'(bytes) + BYTES_PER_BEAT - 1) / BYTES_PER_BEAT;
    bursts = (beats + BURST_BEATS - 1) / BURST_BEATS;
    rem    = int'(bytes) % BYTES_PER_BEAT;
    base   = {addr[ADDR_WIDTH-1:10], 10'b0};
    for (int j = 0; j < bursts; j++) begin
      ab.awaddr = base + addr_t'(j * BURST_BYTES);
      ab.awlen  = (j == bursts - 1) ? beat_count_t'((beats - 1) % BURST_BEATS)
                                    : beat_count_t'(BURST_BEATS - 1);
      exp_aw.push_back(ab);
    end
    for (int i = 0; i < beats; i++) begin
      wb.wdata = data_pool[pool_idx];
      wb.wlast = (i % BURST_BEATS == BURST_BEATS - 1) || (i == beats - 1);
      wb.wstrb = (i == beats - 1) ? final_strobe(rem) : '1;
      exp_w.push_back(wb);
      src_q.push_back(data_pool[pool_idx]);
      pool_idx++;
    end
    req_bursts    = bursts;
    req_b_base    = b_total;
    req_done_base = done_total;
    test_requests++;
    ctrl_addr_offset        = addr;
    ctrl_xfer_size_in_bytes = bytes;
    ctrl_start              = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
  endtask

  // Done must follow the request's final response by one cycle
  task automatic wait_done();
    while (done_total == req_done_base) begin
      @(negedge aclk);
    end
    check_count("responses before done", req_bursts, b_at_done - req_b_base);
    check_count("cycles from final response to done", 1, done_cycle - b_cycle_at_done);
  endtask

  task automatic close_test();
    repeat (3) @(negedge aclk);
    check_count("data beats", exp_w.size(), act_w.size());
    for (int i = 0; i < exp_w.size() && i < act_w.size(); i++) begin
      compare_w($sformatf("beat %0d", i), exp_w[i], act_w[i]);
    end
    check_count("address transfers", exp_aw.size(), act_aw.size());
    for (int i = 0; i < exp_aw.size() && i < act_aw.size(); i++) begin
      compare_aw($sformatf("burst %0d", i), exp_aw[i], act_aw[i]);
    end
    check_count("done pulses", test_requests, done_total - test_done_base);
    if (max_in_flight > LIMIT) begin
      report_failure($sformatf("%0d bursts were in flight at once", max_in_flight));
    end
    tests_run++;
    if (errors == test_err_base) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////
  // Idle outputs before any request, responses always accepted
  task automatic test_reset_state();
    open_test("reset_state");
    compare_flag("awvalid after reset", 1'b0, m_axi_awvalid);
    compare_flag("wvalid after reset", 1'b0, m_axi_wvalid);
    compare_flag("tready after reset", 1'b0, s_axis_tready);
    compare_flag("ctrl_done after reset", 1'b0, ctrl_done);
    compare_flag("bready after reset", 1'b1, m_axi_bready);
    close_test();
  endtask

  task automatic test_single_short();
    open_test("single_short");
    begin_request(32'h0000_0100, 32'd10);
    wait_done();
    close_test();
  endtask

  task automatic test_multi_burst();
    open_test("multi_burst");
    begin_request(32'h0000_4000, 32'd2600);
    wait_done();
    close_test();
  endtask

  task automatic test_random_backpressure();
    open_test("random_backpressure");
    rand_bp = 1'b1;
    begin_request(32'h0000_2340, 32'd1501);
    wait_done();
    rand_bp = 1'b0;
    close_test();
  endtask

  task automatic test_outstanding_limit();
    open_test("outstanding_limit");
    hold_b = 1'b1;
    begin_request(32'h0001_0000, 32'd6144);
    // Let all data drain while the address side sits at the limit
    while (act_w.size() < 1536) begin
      @(negedge aclk);
    end
    repeat (20) @(negedge aclk);
    check_count("addresses with responses held", LIMIT, act_aw.size());
    compare_flag("awvalid with responses held", 1'b0, m_axi_awvalid);
    hold_b = 1'b0;
    wait_done();
    close_test();
  endtask

  // Second request follows straight after the first done
  task automatic test_done_pulse();
    open_test("done_pulse");
    rand_b = 1'b1;
    begin_request(32'h0000_8000, 32'd3000);
    wait_done();
    begin_request(32'h0000_9010, 32'd100);
    wait_done();
    rand_b = 1'b0;
    close_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    areset                  = 1'b1;
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    s_axis_tvalid           = 1'b0;
    s_axis_tdata            = '0;
    m_axi_awready           = 1'b0;
    m_axi_wready            = 1'b0;
    m_axi_bvalid            = 1'b0;
    lfsr_state    = SEED;
    pool_idx      = 0;
    cycle         = 0;
    src_taken     = 0;
    aw_total      = 0;
    wlast_total   = 0;
    b_total       = 0;
    presented     = 0;
    done_total    = 0;
    last_b_cycle  = 0;
    w_next_first  = 1'b1;
    first_counted = 1'b0;
    aw_waiting    = 1'b0;
    rand_bp       = 1'b0;
    hold_b        = 1'b0;
    rand_b        = 1'b0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cur_test      = "reset";
    for (int i = 0; i < TOTAL_BEATS; i++) begin
      data_pool[i] = take_word();
    end
    // Five rising edges under reset, released on the next falling edge
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
    @(negedge aclk);
    test_reset_state();
    test_single_short();
    test_multi_burst();
    test_random_backpressure();
    test_outstanding_limit();
    test_done_pulse();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== axi_write_master.f ====
hdl/axi_write_pkg.sv
hdl/write_request_setup.sv
hdl/write_data_channel.sv
hdl/write_addr_channel.sv
hdl/write_response_tracker.sv
hdl/axi_write_master.sv
dv/axi_write_master_tb.sv

// ==== Makefile ====
# Verilator simulation of the AXI write master testbench

VERILATOR ?= verilator
TOP       ?= axi_write_master_tb
FILELIST  ?= axi_write_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
